// File: logic/btb_pkg.sv
`default_nettype none

package btb_pkg;

    typedef logic [31:0] pc_t;        // Instruction address
    typedef logic [1:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;
    typedef logic [31:0] count_t;     // Statistics counter

    // Sequential fetch step, no compressed instructions
    localparam pc_t INSTR_BYTES = 32'd4;

    // Register map of the control and statistics block
    localparam reg_addr_t REG_CTRL    = 2'd0;
    localparam reg_addr_t REG_HITS    = 2'd1;
    localparam reg_addr_t REG_MISSES  = 2'd2;
    localparam reg_addr_t REG_MISPRED = 2'd3;

endpackage

`default_nettype wire

// File: logic/branch_target_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module branch_target_buffer #(
    parameter int ENTRIES = 8
) (
    input  wire                clk,
    input  wire                reset,
    input  wire                enable,
    input  wire                flush,
    input  wire btb_pkg::pc_t  lookup_pc,
    input  wire                upd_valid,
    input  wire btb_pkg::pc_t  upd_pc,
    input  wire btb_pkg::pc_t  upd_target,
    output logic               hit,
    output btb_pkg::pc_t       target
);

    localparam int IDX_W = $clog2(ENTRIES);

    logic [ENTRIES-1:0] valid;
    btb_pkg::pc_t       tags    [ENTRIES];
    btb_pkg::pc_t       targets [ENTRIES];
    logic [IDX_W-1:0]   alloc_ptr;       // Next FIFO slot to replace

    logic               look_match;
    logic [IDX_W-1:0]   look_idx;
    logic               upd_match;
    logic [IDX_W-1:0]   upd_idx;
    logic [IDX_W-1:0]   wr_idx;

    // Lookup side, scanned downwards so the lowest index wins
    always_comb begin
        look_match = 1'b0;
        look_idx   = '0;
        for (int i = ENTRIES - 1; i >= 0; i--) begin
            if (valid[i] && (tags[i] == lookup_pc)) begin
                look_match = 1'b1;
                look_idx   = IDX_W'(i);
            end
        end
    end

    assign hit    = enable && look_match;  // Prediction off masks the hit only
    assign target = hit ? targets[look_idx] : '0;

    // Training side searches for an existing entry of the branch
    always_comb begin
        upd_match = 1'b0;
        upd_idx   = '0;
        for (int i = ENTRIES - 1; i >= 0; i--) begin
            if (valid[i] && (tags[i] == upd_pc)) begin
                upd_match = 1'b1;
                upd_idx   = IDX_W'(i);
            end
        end
    end

    // Rewrite a known branch in place, else take the FIFO slot
    assign wr_idx = upd_match ? upd_idx : alloc_ptr;

    // Tag and target storage
    always_ff @(posedge clk) begin
        if (upd_valid) begin
            tags[wr_idx]    <= upd_pc;
            targets[wr_idx] <= upd_target;
        end
    end

    // Valid bits and allocation pointer
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid     <= '0;                 // Flush beats a training write
            alloc_ptr <= '0;
        end else if (upd_valid && !upd_match) begin
            valid[alloc_ptr] <= 1'b1;
            alloc_ptr        <= alloc_ptr + IDX_W'(1);  // Wraps at ENTRIES
        end
    end

endmodule

`default_nettype wire

// File: logic/fetch_pc_gen.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_pc_gen #(
    parameter btb_pkg::pc_t RESET_PC = 32'h0000_0000
) (
    input  wire                clk,
    input  wire                reset,
    input  wire                stall,
    input  wire                redirect,
    input  wire btb_pkg::pc_t  redirect_pc,
    input  wire                pred_hit,
    input  wire btb_pkg::pc_t  pred_target,
    output btb_pkg::pc_t       fetch_pc
);

    btb_pkg::pc_t next_pc;

    // Redirect first, then stall, then prediction, then sequential
    always_comb begin
        if (redirect) begin
            next_pc = redirect_pc;           // Correction ignores stall
        end else if (stall) begin
            next_pc = fetch_pc;
        end else if (pred_hit) begin
            next_pc = pred_target;
        end else begin
            next_pc = fetch_pc + btb_pkg::INSTR_BYTES;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_pc <= RESET_PC;
        end else begin
            fetch_pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

// File: logic/branch_resolve.sv
`timescale 1ns/10ps
`default_nettype none

module branch_resolve (
    input  wire                ex_valid,
    input  wire btb_pkg::pc_t  ex_pc,
    input  wire                ex_taken,
    input  wire btb_pkg::pc_t  ex_target,
    input  wire                ex_pred_hit,
    input  wire btb_pkg::pc_t  ex_pred_target,
    output logic               redirect,
    output btb_pkg::pc_t       redirect_pc,
    output logic               upd_valid,
    output btb_pkg::pc_t       upd_pc,
    output btb_pkg::pc_t       upd_target,
    output logic               mispredict
);

    logic pred_correct_taken;
    logic wrong;

    // A taken branch was right only if it hit with the same target
    assign pred_correct_taken = ex_pred_hit && (ex_pred_target == ex_target);

    always_comb begin
        if (ex_taken) begin
            wrong = !pred_correct_taken;
        end else begin
            wrong = ex_pred_hit;             // Predicted taken, fell through
        end
    end

    assign redirect    = ex_valid && wrong;
    assign redirect_pc = ex_taken ? ex_target : (ex_pc + btb_pkg::INSTR_BYTES);
    assign mispredict  = redirect;

    // Every taken branch trains the buffer, right or wrong
    assign upd_valid  = ex_valid && ex_taken;
    assign upd_pc     = ex_pc;
    assign upd_target = ex_target;

endmodule

`default_nettype wire

// File: logic/btb_ctrl_regs.sv
`timescale 1ns/10ps
`default_nettype none

module btb_ctrl_regs (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     reg_write,
    input  wire btb_pkg::reg_addr_t reg_addr,
    input  wire btb_pkg::reg_data_t reg_wdata,
    input  wire                     stall,
    input  wire                     lookup_hit,
    input  wire                     mispredict,
    output btb_pkg::reg_data_t      reg_rdata,
    output logic                    enable,
    output logic                    flush
);

    btb_pkg::count_t hit_count;
    btb_pkg::count_t miss_count;
    btb_pkg::count_t mispred_count;
    logic            ctrl_write;

    assign ctrl_write = reg_write && (reg_addr == btb_pkg::REG_CTRL);

    // Enable level and flush strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            enable <= 1'b1;                  // Prediction on out of reset
            flush  <= 1'b0;
        end else begin
            flush <= ctrl_write && reg_wdata[1];
            if (ctrl_write) begin
                enable <= reg_wdata[0];
            end
        end
    end

    // Lookup statistics, nothing counted while fetch is stalled
    always_ff @(posedge clk) begin
        if (reset) begin
            hit_count     <= '0;
            miss_count    <= '0;
            mispred_count <= '0;
        end else begin
            if (!stall && lookup_hit) begin
                hit_count <= hit_count + 1'b1;
            end
            if (!stall && !lookup_hit) begin
                miss_count <= miss_count + 1'b1;  // Includes cycles with enable off
            end
            if (mispredict) begin
                mispred_count <= mispred_count + 1'b1;
            end
        end
    end

    // Read mux
    always_comb begin
        case (reg_addr)
            btb_pkg::REG_CTRL:    reg_rdata = btb_pkg::reg_data_t'(enable);
            btb_pkg::REG_HITS:    reg_rdata = hit_count;
            btb_pkg::REG_MISSES:  reg_rdata = miss_count;
            btb_pkg::REG_MISPRED: reg_rdata = mispred_count;
            default:              reg_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/btb_fetch_top.sv
`timescale 1ns/10ps
`default_nettype none

module btb_fetch_top #(
    parameter int           ENTRIES  = 8,
    parameter btb_pkg::pc_t RESET_PC = 32'h0000_0000
) (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     stall,
    input  wire                     ex_valid,
    input  wire btb_pkg::pc_t       ex_pc,
    input  wire                     ex_taken,
    input  wire btb_pkg::pc_t       ex_target,
    input  wire                     ex_pred_hit,
    input  wire btb_pkg::pc_t       ex_pred_target,
    input  wire                     reg_write,
    input  wire btb_pkg::reg_addr_t reg_addr,
    input  wire btb_pkg::reg_data_t reg_wdata,
    output btb_pkg::pc_t            fetch_pc,
    output logic                    pred_hit,
    output btb_pkg::pc_t            pred_target,
    output btb_pkg::reg_data_t      reg_rdata
);

    logic         redirect;
    btb_pkg::pc_t redirect_pc;
    logic         upd_valid;
    btb_pkg::pc_t upd_pc;
    btb_pkg::pc_t upd_target;
    logic         mispredict;
    logic         enable;
    logic         flush;

    branch_target_buffer #(
        .ENTRIES (ENTRIES)
    ) u_btb (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable),
        .flush      (flush),
        .lookup_pc  (fetch_pc),
        .upd_valid  (upd_valid),
        .upd_pc     (upd_pc),
        .upd_target (upd_target),
        .hit        (pred_hit),
        .target     (pred_target)
    );

    fetch_pc_gen #(
        .RESET_PC (RESET_PC)
    ) u_pc_gen (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pred_hit    (pred_hit),
        .pred_target (pred_target),
        .fetch_pc    (fetch_pc)
    );

    branch_resolve u_resolve (
        .ex_valid       (ex_valid),
        .ex_pc          (ex_pc),
        .ex_taken       (ex_taken),
        .ex_target      (ex_target),
        .ex_pred_hit    (ex_pred_hit),
        .ex_pred_target (ex_pred_target),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .upd_valid      (upd_valid),
        .upd_pc         (upd_pc),
        .upd_target     (upd_target),
        .mispredict     (mispredict)
    );

    btb_ctrl_regs u_regs (
        .clk        (clk),
        .reset      (reset),
        .reg_write  (reg_write),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .stall      (stall),
        .lookup_hit (pred_hit),
        .mispredict (mispredict),
        .reg_rdata  (reg_rdata),
        .enable     (enable),
        .flush      (flush)
    );

endmodule

`default_nettype wire

// File: verification/tb_btb_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module tb_btb_fetch;

    localparam int           ENTRIES    = 8;
    localparam btb_pkg::pc_t RESET_PC   = 32'h0000_0000;
    localparam int           NUM_CYCLES = 3000;
    localparam int           TIMEOUT    = 4 * (NUM_CYCLES + 4 + 3);  // Reset and final reads

    logic               clk, reset, stall, reg_write;
    logic               ex_valid, ex_taken, ex_pred_hit, pred_hit;
    btb_pkg::pc_t       ex_pc, ex_target, ex_pred_target, fetch_pc, pred_target;
    btb_pkg::reg_addr_t reg_addr;
    btb_pkg::reg_data_t reg_wdata, reg_rdata;

    // Reference model of buffer, fetch address and registers
    logic               m_valid [ENTRIES];
    btb_pkg::pc_t       m_tag [ENTRIES];
    btb_pkg::pc_t       m_tgt [ENTRIES];
    int                 m_ptr;
    logic               m_enable, m_flush;
    btb_pkg::pc_t       m_pc;
    btb_pkg::count_t    m_hits, m_misses, m_mispred;

    // Fetches still waiting for their branch report
    btb_pkg::pc_t       q_pc [$];
    logic               q_hit [$];
    btb_pkg::pc_t       q_tgt [$];

    integer             seed;
    int                 cycles = 0;

    btb_fetch_top #(.ENTRIES(ENTRIES), .RESET_PC(RESET_PC)) u_dut (
        .clk(clk), .reset(reset), .stall(stall),
        .ex_valid(ex_valid), .ex_pc(ex_pc), .ex_taken(ex_taken), .ex_target(ex_target),
        .ex_pred_hit(ex_pred_hit), .ex_pred_target(ex_pred_target),
        .reg_write(reg_write), .reg_addr(reg_addr), .reg_wdata(reg_wdata),
        .fetch_pc(fetch_pc), .pred_hit(pred_hit), .pred_target(pred_target),
        .reg_rdata(reg_rdata)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT) begin
            $display("Timeout: the test did not finish within %0d cycles", TIMEOUT);
            stop_on_error();
        end
    end

    task automatic stop_on_error();
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_pc(input string name, input btb_pkg::pc_t got, input btb_pkg::pc_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_hit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_reg(input string name, input btb_pkg::reg_data_t got,
                             input btb_pkg::reg_data_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    // Index of the lowest valid entry with this address or -1
    function automatic int find_entry(input btb_pkg::pc_t pc);
        find_entry = -1;
        for (int i = ENTRIES - 1; i >= 0; i--) begin
            if (m_valid[i] && (m_tag[i] == pc)) find_entry = i;
        end
    endfunction

    function automatic btb_pkg::reg_data_t read_model(input btb_pkg::reg_addr_t a);
        case (a)
            btb_pkg::REG_CTRL:    read_model = {31'd0, m_enable};  // Flush bit reads 0
            btb_pkg::REG_HITS:    read_model = m_hits;
            btb_pkg::REG_MISSES:  read_model = m_misses;
            default:              read_model = m_mispred;
        endcase
    endfunction

    // Random inputs for one cycle applied on the falling edge
    task automatic drive_random();
        logic [31:0] r, r2;
        r  = $random(seed);
        r2 = $random(seed);
        stall    = (r[13:12] == 2'd0);
        ex_valid = 1'b0;
        if ((q_pc.size() > 0) && (r[0] || q_pc.size() > 6)) begin
            ex_valid       = 1'b1;
            ex_pc          = q_pc.pop_front();
            ex_pred_hit    = q_hit.pop_front();
            ex_pred_target = q_tgt.pop_front();
            ex_taken       = (r[2:1] != 2'd0);
            // Mostly agree with a prediction, else a target in a small loop
            ex_target = (ex_pred_hit && r[4:3] != 2'd0) ? ex_pred_target
                                                         : {26'd0, r[9:6], 2'b00};
        end
        reg_write = (r2[3:0] == 4'd0);
        reg_addr  = (reg_write && r2[7:6] != 2'd0) ? btb_pkg::REG_CTRL : r2[5:4];
        reg_wdata = {30'd0, r2[11:10] == 2'd0, r2[9:8] != 2'd0};
    endtask

    // Compare outputs mid-cycle, then advance the model over the next rising edge
    task automatic check_and_advance();
        int           idx;
        logic         exp_hit, wrong, redirect;
        btb_pkg::pc_t exp_tgt, redir_pc;
        idx     = find_entry(m_pc);
        exp_hit = m_enable && (idx >= 0);
        exp_tgt = exp_hit ? m_tgt[idx] : '0;
        check_pc("fetch_pc", fetch_pc, m_pc);
        check_hit("pred_hit", pred_hit, exp_hit);
        if (exp_hit) check_pc("pred_target", pred_target, exp_tgt);
        check_reg("reg_rdata", reg_rdata, read_model(reg_addr));

        // The three misprediction cases
        wrong    = (ex_taken && !ex_pred_hit)
                || (ex_taken && ex_pred_hit && (ex_pred_target != ex_target))
                || (!ex_taken && ex_pred_hit);
        redirect = ex_valid && wrong;
        redir_pc = ex_taken ? ex_target : ex_pc + btb_pkg::INSTR_BYTES;
        if (!stall) begin
            q_pc.push_back(m_pc);
            q_hit.push_back(exp_hit);
            q_tgt.push_back(exp_tgt);
            if (exp_hit) m_hits = m_hits + 1;
            else m_misses = m_misses + 1;
        end
        if (redirect) begin
            m_mispred = m_mispred + 1;
            q_pc.delete();  // Younger fetches are squashed
            q_hit.delete();
            q_tgt.delete();
        end
        if (redirect) m_pc = redir_pc;
        else if (!stall) m_pc = exp_hit ? exp_tgt : m_pc + btb_pkg::INSTR_BYTES;

        if (m_flush) begin
            foreach (m_valid[i]) m_valid[i] = 1'b0;
            m_ptr = 0;
        end else if (ex_valid && ex_taken) begin
            idx = find_entry(ex_pc);
            if (idx >= 0) begin
                m_tgt[idx] = ex_target;  // Retrain in place
            end else begin
                m_tag[m_ptr]   = ex_pc;
                m_tgt[m_ptr]   = ex_target;
                m_valid[m_ptr] = 1'b1;
                m_ptr          = (m_ptr + 1) % ENTRIES;
            end
        end
        m_flush = reg_write && (reg_addr == btb_pkg::REG_CTRL) && reg_wdata[1];
        if (reg_write && (reg_addr == btb_pkg::REG_CTRL)) m_enable = reg_wdata[0];
    endtask

    initial begin
        seed  = 32'hbcc0d46c;
        reset = 1'b1;
        stall = 1'b0;
        ex_valid = 1'b0;
        ex_taken = 1'b0;
        ex_pred_hit = 1'b0;
        ex_pc = '0;
        ex_target = '0;
        ex_pred_target = '0;
        reg_write = 1'b0;
        reg_addr = '0;
        reg_wdata = '0;
        foreach (m_valid[i]) m_valid[i] = 1'b0;
        m_ptr = 0;
        m_enable = 1'b1;
        m_flush = 1'b0;
        m_pc = RESET_PC;
        m_hits = '0;
        m_misses = '0;
        m_mispred = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int n = 0; n < NUM_CYCLES; n++) begin
            drive_random();
            #5;
            check_and_advance();
            @(negedge clk);
        end
        // Quiet stalled cycles to read back every counter
        for (int a = 1; a < 4; a++) begin
            stall     = 1'b1;
            ex_valid  = 1'b0;
            reg_write = 1'b0;
            reg_addr  = btb_pkg::reg_addr_t'(a);
            #5;
            check_and_advance();
            @(negedge clk);
        end
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: btb_fetch.f
logic/btb_pkg.sv
logic/branch_target_buffer.sv
logic/fetch_pc_gen.sv
logic/branch_resolve.sv
logic/btb_ctrl_regs.sv
logic/btb_fetch_top.sv
verification/tb_btb_fetch.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing -Wno-fatal --top-module tb_btb_fetch -f btb_fetch.f -Mdir obj_dir
	@out=$$(./obj_dir/Vtb_btb_fetch); echo "$$out"; echo "$$out" | grep -q "No errors"

clean:
	rm -rf obj_dir
